// ==== Makefile ====
# Verilator build and run for the Camera Link camera model

VERILATOR ?= verilator
TOP       ?= cl_camera_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -qxF '** PASS **' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/cl_camera_top.sv ====
`timescale 1ns/1ps

module cl_camera_top (
  input  logic reset,
  input  logic cl_z_pclk,
  input  logic reg_wr,
  input  cl_pkg::reg_addr_t reg_addr,
  input  cl_pkg::reg_data_t reg_wdata,
  output cl_pkg::reg_data_t reg_rdata,
  output logic fval,
  output logic lval,
  output cl_pkg::tap_t tap_a,
  output cl_pkg::tap_t tap_b,
  output cl_pkg::tap_t tap_c,
  output cl_pkg::tap_t tap_d,
  output cl_pkg::tap_t tap_e,
  output cl_pkg::tap_t tap_f,
  output cl_pkg::tap_t tap_g,
  output cl_pkg::tap_t tap_h,
  output cl_pkg::tap_t tap_i,
  output cl_pkg::tap_t tap_j,
  output logic out_valid,
  output cl_pkg::pixel_word_t out_data,
  output logic out_sof,
  output logic out_eol,
  input  logic credit_ret
);
  import cl_pkg::*;

  frame_cnt_t drop_count;

  cl_cfg_if cfg ();
  cl_video_if vid ();

  cl_timing_regs u_regs (
    .reset(reset),
    .cl_z_pclk(cl_z_pclk),
    .reg_wr(reg_wr),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata),
    .drop_count(drop_count),
    .cfg(cfg.src)
  );

  cl_frame_timing u_timing (
    .reset(reset),
    .cl_z_pclk(cl_z_pclk),
    .cfg(cfg.dst),
    .vid(vid.src)
  );

  cl_tap_pattern u_pattern (
    .reset(reset),
    .cl_z_pclk(cl_z_pclk),
    .vid(vid.pattern)
  );

  cl_grabber u_grabber (
    .reset(reset),
    .cl_z_pclk(cl_z_pclk),
    .vid(vid.sink),
    .out_valid(out_valid),
    .out_data(out_data),
    .out_sof(out_sof),
    .out_eol(out_eol),
    .credit_ret(credit_ret),
    .drop_count(drop_count)
  );

  assign fval = vid.fval_d;  // strobes leave aligned with the taps
  assign lval = vid.lval_d;
  assign tap_a = vid.taps[0];
  assign tap_b = vid.taps[1];
  assign tap_c = vid.taps[2];
  assign tap_d = vid.taps[3];
  assign tap_e = vid.taps[4];
  assign tap_f = vid.taps[5];
  assign tap_g = vid.taps[6];
  assign tap_h = vid.taps[7];
  assign tap_i = vid.taps[8];
  assign tap_j = vid.taps[9];

endmodule

// ==== design/cl_cfg_if.sv ====
`timescale 1ns/1ps

interface cl_cfg_if;
  import cl_pkg::*;

  logic enable;
  blank_cnt_t fval_low;
  blank_cnt_t lval_low;
  col_cnt_t n_col;
  row_cnt_t n_row;
  logic frame_done;  // one clock at the end of every frame

  modport src (
    output enable, fval_low, lval_low, n_col, n_row,
    input frame_done
  );

  modport dst (
    input enable, fval_low, lval_low, n_col, n_row,
    output frame_done
  );
endinterface

// ==== design/cl_frame_timing.sv ====
`timescale 1ns/1ps

module cl_frame_timing (
  input  logic reset,
  input  logic cl_z_pclk,
  cl_cfg_if.dst cfg,
  cl_video_if.src vid
);
  import cl_pkg::*;

  cam_state_t state;
  blank_cnt_t blank_cnt;
  blank_cnt_t lat_lval_low;
  col_cnt_t lat_n_col;
  row_cnt_t lat_n_row;

  always_ff @(posedge reset or posedge cl_z_pclk) begin
    if (cl_z_pclk) begin
      state <= ST_NOFRAME;
      blank_cnt <= '0;
      lat_lval_low <= DEF_LVAL_LOW;
      lat_n_col <= DEF_N_COL;
      lat_n_row <= DEF_N_ROW;
      vid.fval <= 1'b0;
      vid.lval <= 1'b0;
      vid.col <= '0;
      vid.row <= '0;
      vid.fval_d <= 1'b0;
      vid.lval_d <= 1'b0;
      vid.col_d <= '0;
      cfg.frame_done <= 1'b0;
    end else begin
      cfg.frame_done <= 1'b0;
      case (state)
        ST_NOFRAME: begin
          if (!cfg.enable) begin
            blank_cnt <= '0;  // hold the vertical blank while disabled
          end else if (blank_cnt == cfg.fval_low) begin
            // geometry is frozen here so mid-frame writes wait a frame
            lat_lval_low <= cfg.lval_low;
            lat_n_col <= cfg.n_col;
            lat_n_row <= cfg.n_row;
            blank_cnt <= '0;
            vid.fval <= 1'b1;
            vid.lval <= 1'b1;
            vid.col <= '0;
            vid.row <= '0;
            state <= ST_LVAL;
          end else begin
            blank_cnt <= blank_cnt + 1'b1;
          end
        end
        ST_LVAL: begin
          if (vid.col == lat_n_col - 1'b1) begin
            vid.lval <= 1'b0;
            vid.col <= '0;
            if (vid.row == lat_n_row - 1'b1) begin
              vid.fval <= 1'b0;  // fval drops together with the last lval
              cfg.frame_done <= 1'b1;
              state <= ST_NOFRAME;
            end else begin
              state <= ST_INTERLINE;
            end
          end else begin
            vid.col <= vid.col + 1'b1;
          end
        end
        ST_INTERLINE: begin
          if (blank_cnt == lat_lval_low) begin
            blank_cnt <= '0;
            vid.lval <= 1'b1;
            vid.row <= vid.row + 1'b1;
            state <= ST_LVAL;
          end else begin
            blank_cnt <= blank_cnt + 1'b1;
          end
        end
        default: state <= ST_NOFRAME;
      endcase

      vid.fval_d <= vid.fval;  // matches the one clock of the tap register
      vid.lval_d <= vid.lval;
      vid.col_d <= vid.col;
    end
  end

  a_lval_in_fval: assert property (@(posedge reset) disable iff (cl_z_pclk)
    vid.lval |-> vid.fval);

  a_col_range: assert property (@(posedge reset) disable iff (cl_z_pclk)
    vid.lval |-> vid.col < lat_n_col);

endmodule

// ==== design/cl_grabber.sv ====
`timescale 1ns/1ps

module cl_grabber (
  input  logic reset,
  input  logic cl_z_pclk,
  cl_video_if.sink vid,
  output logic out_valid,
  output cl_pkg::pixel_word_t out_data,
  output logic out_sof,
  output logic out_eol,
  input  logic credit_ret,
  output cl_pkg::frame_cnt_t drop_count
);
  import cl_pkg::*;

  logic [$bits(pixel_word_t)+1:0] mem [BUF_DEPTH];  // {eol, sof, word}
  logic [BUF_AW-1:0] wr_ptr;
  logic [BUF_AW-1:0] rd_ptr;
  logic [BUF_AW:0] count;
  logic [CREDIT_W-1:0] credits;
  logic first_line;
  logic full;
  logic push;
  logic pop;
  logic in_sof;
  logic in_eol;

  assign full = count == (BUF_AW+1)'(BUF_DEPTH);
  assign push = vid.lval_d && !full;
  assign pop = count != '0 && credits != '0;
  assign in_sof = first_line && vid.col_d == '0;
  assign in_eol = !vid.lval;  // undelayed lval already shows the line end

  always_ff @(posedge reset or posedge cl_z_pclk) begin
    if (cl_z_pclk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= CREDIT_W'(CREDIT_MAX);
      first_line <= 1'b1;
      out_valid <= 1'b0;
      drop_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (BUF_AW+1)'(push) - (BUF_AW+1)'(pop);
      credits <= credits + CREDIT_W'(credit_ret) - CREDIT_W'(pop);  // both may land together
      out_valid <= pop;

      if (vid.lval_d && full && drop_count != '1) begin
        drop_count <= drop_count + 1'b1;  // saturates at all ones
      end

      if (!vid.fval_d) begin
        first_line <= 1'b1;
      end else if (vid.lval_d && in_eol) begin
        first_line <= 1'b0;
      end
    end
  end

  always_ff @(posedge reset) begin
    if (push) begin
      mem[wr_ptr] <= {in_eol, in_sof, pixel_word_t'(vid.taps)};
    end
    if (pop) begin
      {out_eol, out_sof, out_data} <= mem[rd_ptr];
    end
  end

  // the receiver must never hand back more credits than it was given
  a_credit_max: assert property (@(posedge reset) disable iff (cl_z_pclk)
    credits <= CREDIT_W'(CREDIT_MAX));

  a_valid_has_credit: assert property (@(posedge reset) disable iff (cl_z_pclk)
    out_valid |-> $past(credits) != '0);

endmodule

// ==== design/cl_pkg.sv ====
package cl_pkg;

  localparam int N_TAPS = 10;

  typedef logic [7:0] tap_t;
  typedef logic [N_TAPS*8-1:0] pixel_word_t;  // tap a sits in the low byte
  typedef logic [9:0] col_cnt_t;
  typedef logic [10:0] row_cnt_t;
  typedef logic [9:0] blank_cnt_t;
  typedef logic [15:0] frame_cnt_t;
  typedef logic [2:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  typedef enum logic [1:0] {
    ST_NOFRAME,
    ST_LVAL,
    ST_INTERLINE
  } cam_state_t;

  // idle byte of each tap, a through j
  localparam tap_t TAP_BASE [N_TAPS] = '{
    8'h0A, 8'h0B, 8'h0C, 8'h0D, 8'h0E, 8'h0F, 8'h09, 8'h06, 8'h01, 8'h07
  };

  localparam int CREDIT_MAX = 4;
  localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);
  localparam int BUF_DEPTH = 8;
  localparam int BUF_AW = $clog2(BUF_DEPTH);  // depth must stay a power of two

  localparam reg_addr_t REG_CTRL = 3'd0;
  localparam reg_addr_t REG_FVAL_LOW = 3'd1;
  localparam reg_addr_t REG_LVAL_LOW = 3'd2;
  localparam reg_addr_t REG_N_COL = 3'd3;
  localparam reg_addr_t REG_N_ROW = 3'd4;
  localparam reg_addr_t REG_FRAME_CNT = 3'd5;  // read only
  localparam reg_addr_t REG_DROP_CNT = 3'd6;  // read only

  localparam blank_cnt_t DEF_FVAL_LOW = 10'd40;
  localparam blank_cnt_t DEF_LVAL_LOW = 10'd7;
  localparam col_cnt_t DEF_N_COL = 10'd6;
  localparam row_cnt_t DEF_N_ROW = 11'd4;

endpackage

// ==== design/cl_tap_pattern.sv ====
`timescale 1ns/1ps

module cl_tap_pattern (
  input  logic reset,
  input  logic cl_z_pclk,
  cl_video_if.pattern vid
);
  import cl_pkg::*;

  always_ff @(posedge reset or posedge cl_z_pclk) begin
    if (cl_z_pclk) begin
      for (int k = 0; k < N_TAPS; k++) begin
        vid.taps[k] <= TAP_BASE[k];
      end
    end else begin
      for (int k = 0; k < N_TAPS; k++) begin
        if (vid.fval) begin
          // row in the top bits, column parity in bit 4, tap id below
          vid.taps[k] <= {vid.row[2:0], vid.col[0], TAP_BASE[k][3:0]};
        end else begin
          vid.taps[k] <= TAP_BASE[k];
        end
      end
    end
  end

  // rows only step forward by one inside a frame
  a_row_step: assert property (@(posedge reset) disable iff (cl_z_pclk)
    vid.fval && $past(vid.fval) && vid.row != $past(vid.row)
    |-> vid.row == $past(vid.row) + 1'b1);

  // within a line every new column flips the parity carried in bit 4
  a_col_toggle: assert property (@(posedge reset) disable iff (cl_z_pclk)
    vid.fval && vid.col != '0 |-> vid.col[0] != $past(vid.col[0]));

endmodule

// ==== design/cl_timing_regs.sv ====
`timescale 1ns/1ps

module cl_timing_regs (
  input  logic reset,
  input  logic cl_z_pclk,
  input  logic reg_wr,
  input  cl_pkg::reg_addr_t reg_addr,
  input  cl_pkg::reg_data_t reg_wdata,
  output cl_pkg::reg_data_t reg_rdata,
  input  cl_pkg::frame_cnt_t drop_count,
  cl_cfg_if.src cfg
);
  import cl_pkg::*;

  frame_cnt_t frame_cnt;

  always_ff @(posedge reset or posedge cl_z_pclk) begin
    if (cl_z_pclk) begin
      cfg.enable <= 1'b0;  // camera stays idle until software enables it
      cfg.fval_low <= DEF_FVAL_LOW;
      cfg.lval_low <= DEF_LVAL_LOW;
      cfg.n_col <= DEF_N_COL;
      cfg.n_row <= DEF_N_ROW;
      frame_cnt <= '0;
    end else begin
      if (reg_wr) begin
        case (reg_addr)
          REG_CTRL: cfg.enable <= reg_wdata[0];
          REG_FVAL_LOW: cfg.fval_low <= blank_cnt_t'(reg_wdata);
          REG_LVAL_LOW: cfg.lval_low <= blank_cnt_t'(reg_wdata);
          REG_N_COL: cfg.n_col <= col_cnt_t'(reg_wdata);
          REG_N_ROW: cfg.n_row <= row_cnt_t'(reg_wdata);
          default: ;  // status addresses ignore writes
        endcase
      end
      if (cfg.frame_done) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (reg_addr)
      REG_CTRL: reg_rdata = reg_data_t'(cfg.enable);
      REG_FVAL_LOW: reg_rdata = reg_data_t'(cfg.fval_low);
      REG_LVAL_LOW: reg_rdata = reg_data_t'(cfg.lval_low);
      REG_N_COL: reg_rdata = reg_data_t'(cfg.n_col);
      REG_N_ROW: reg_rdata = reg_data_t'(cfg.n_row);
      REG_FRAME_CNT: reg_rdata = frame_cnt;
      REG_DROP_CNT: reg_rdata = drop_count;
      default: reg_rdata = '0;
    endcase
  end

  // a zero geometry would hang the timing generator in one line forever
  a_n_col_nonzero: assert property (@(posedge reset) disable iff (cl_z_pclk)
    reg_wr && reg_addr == REG_N_COL |-> col_cnt_t'(reg_wdata) != '0);

  a_n_row_nonzero: assert property (@(posedge reset) disable iff (cl_z_pclk)
    reg_wr && reg_addr == REG_N_ROW |-> row_cnt_t'(reg_wdata) != '0);

endmodule

// ==== design/cl_video_if.sv ====
`timescale 1ns/1ps

interface cl_video_if;
  import cl_pkg::*;

  logic fval;
  logic lval;
  col_cnt_t col;
  row_cnt_t row;
  tap_t [N_TAPS-1:0] taps;  // registered one clock after col and row

  // copies delayed by one clock so they line up with taps
  logic fval_d;
  logic lval_d;
  col_cnt_t col_d;

  modport src (output fval, lval, col, row, fval_d, lval_d, col_d);

  modport pattern (input fval, col, row, output taps);

  // lval is read one clock early to spot the last pixel of a line
  modport sink (input lval, fval_d, lval_d, col_d, taps);
endinterface

// ==== sources.f ====
design/cl_pkg.sv
design/cl_cfg_if.sv
design/cl_video_if.sv
design/cl_timing_regs.sv
design/cl_frame_timing.sv
design/cl_tap_pattern.sv
design/cl_grabber.sv
design/cl_camera_top.sv
tb/cl_camera_tb.sv

// ==== tb/cl_camera_tb.sv ====
`timescale 1ns/1ps

module cl_camera_tb;
  import cl_pkg::*;

  localparam int TMO = 2000;
  localparam int M_PROMPT = 0;
  localparam int M_RANDOM = 1;
  localparam int M_HOLD = 2;
  localparam int N_STEPS = 5;
  localparam tap_t BASE_TAB [N_TAPS] = '{
    8'h0A, 8'h0B, 8'h0C, 8'h0D, 8'h0E, 8'h0F, 8'h09, 8'h06, 8'h01, 8'h07
  };

  typedef struct packed {
    int fval_low;
    int lval_low;
    int n_col;
    int n_row;
    int mid_col;  // nonzero means n_col is rewritten while the frame runs
    int frames;
    int mode;
    int exp_frames;  // frame counter value after this step
  } step_t;

  step_t steps [N_STEPS] = '{
    '{5, 3, 6, 4, 0, 2, M_PROMPT, 2},
    '{3, 2, 5, 3, 9, 1, M_PROMPT, 3},
    '{30, 3, 4, 2, 0, 2, M_RANDOM, 5},
    '{2, 2, 6, 4, 0, 1, M_HOLD, 6},
    '{6, 4, 3, 10, 0, 1, M_PROMPT, 7}
  };

  logic reset;
  logic cl_z_pclk;
  logic reg_wr;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic fval;
  logic lval;
  tap_t tap_w [N_TAPS];
  logic out_valid;
  pixel_word_t out_data;
  logic out_sof;
  logic out_eol;
  logic credit_ret;

  int errors = 0;
  int checks = 0;
  int timeouts = 0;
  int rx_cnt = 0;
  int owed = 0;  // words received whose credit is not back yet
  int mode = M_PROMPT;
  logic chk_content = 1'b0;
  logic tb_en = 1'b0;
  int exp_fval_low;
  int exp_lval_low;
  int exp_col;
  int exp_row;
  logic prev_fval = 1'b0;
  logic prev_lval = 1'b0;
  logic fall_armed = 1'b0;
  int hi_run = 0;
  int lo_run = 0;
  int fv_lo = 0;
  int lines = 0;

  cl_camera_top dut0 (
    .reset(reset), .cl_z_pclk(cl_z_pclk),
    .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .fval(fval), .lval(lval),
    .tap_a(tap_w[0]), .tap_b(tap_w[1]), .tap_c(tap_w[2]), .tap_d(tap_w[3]),
    .tap_e(tap_w[4]), .tap_f(tap_w[5]), .tap_g(tap_w[6]), .tap_h(tap_w[7]),
    .tap_i(tap_w[8]), .tap_j(tap_w[9]),
    .out_valid(out_valid), .out_data(out_data), .out_sof(out_sof), .out_eol(out_eol),
    .credit_ret(credit_ret)
  );

  always #20 reset = ~reset;

  task automatic check_tap(string name, tap_t got, tap_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, pixel_word_t got, pixel_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(string name, reg_data_t got, reg_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  // row index in the top bits, column parity in bit 4, tap id below
  function automatic tap_t expected_tap(int k, int c, int r);
    tap_t t;
    t[3:0] = BASE_TAB[k][3:0];
    t[4] = c[0];
    t[7:5] = r[2:0];
    return t;
  endfunction

  function automatic pixel_word_t expected_word(int c, int r);
    pixel_word_t w;
    for (int k = 0; k < N_TAPS; k++) begin
      w[k*8 +: 8] = expected_tap(k, c, r);
    end
    return w;
  endfunction

  task automatic note_timeout(string why);
    timeouts++;
    $display("timeout: %s", why);
  endtask

  // strobe lengths and tap values as seen at the camera ports
  task automatic watch_geometry();
    if (fval && !prev_fval) begin
      if (fall_armed) check_count("fval low clocks", fv_lo, exp_fval_low + 1);
      lines = 0;
    end
    if (lval && !prev_lval) begin
      if (prev_fval) check_count("lval low clocks", lo_run, exp_lval_low + 1);
      lines++;
    end
    if (!lval && prev_lval) check_count("lval high clocks", hi_run, exp_col);
    if (!fval && prev_fval) begin
      check_count("lines per frame", lines, exp_row);
      fall_armed = tb_en;  // only back-to-back frames give a real vertical blank
    end
    hi_run = lval ? hi_run + 1 : 0;
    lo_run = lval ? 0 : lo_run + 1;
    fv_lo = fval ? 0 : fv_lo + 1;
    if (lval) begin
      for (int k = 0; k < N_TAPS; k++) begin
        check_tap($sformatf("tap %0d", k), tap_w[k], expected_tap(k, hi_run - 1, lines - 1));
      end
    end
    prev_fval = fval;
    prev_lval = lval;
  endtask

  // one clock of the receiver model, credit return and port monitor
  task automatic tick();
    int idx;
    int c;
    @(posedge reset);
    #2;
    credit_ret = 1'b0;
    if (out_valid === 1'b1) begin
      if (chk_content) begin
        idx = rx_cnt % (exp_col * exp_row);
        c = idx % exp_col;
        check_word("out_data", out_data, expected_word(c, idx / exp_col));
        check_bit("out_sof", out_sof, idx == 0);
        check_bit("out_eol", out_eol, c == exp_col - 1);
      end
      rx_cnt++;
      owed++;
    end
    if (owed > 0 && (mode == M_PROMPT || (mode == M_RANDOM && $urandom_range(1, 0) == 0))) begin
      credit_ret = 1'b1;
      owed--;
    end
    watch_geometry();
  endtask

  task automatic write_reg(reg_addr_t a, reg_data_t d);
    reg_wr = 1'b1;
    reg_addr = a;
    reg_wdata = d;
    tick();
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(reg_addr_t a, output reg_data_t d);
    reg_addr = a;
    #1;
    d = reg_rdata;
  endtask

  task automatic write_check(reg_addr_t a, reg_data_t wr, reg_data_t exp, string name);
    reg_data_t d;
    write_reg(a, wr);
    read_reg(a, d);
    check_reg(name, d, exp);
  endtask

  task automatic wait_fval(logic level);
    int n;
    n = 0;
    while (fval !== level && n < TMO) begin
      tick();
      n++;
    end
    if (fval !== level) note_timeout($sformatf("fval never went to %b", level));
  endtask

  task automatic wait_words(int total, reg_data_t drop0);
    reg_data_t d;
    int n;
    n = 0;
    read_reg(REG_DROP_CNT, d);
    while (rx_cnt + int'(d) - int'(drop0) < total && n < TMO) begin
      tick();
      read_reg(REG_DROP_CNT, d);
      n++;
    end
    if (rx_cnt + int'(d) - int'(drop0) < total) note_timeout("frame words never all accounted for");
    check_count("words plus drops", rx_cnt + int'(d) - int'(drop0), total);
    if (mode != M_HOLD && chk_content) check_count("dropped words", int'(d) - int'(drop0), 0);
  endtask

  task automatic wait_credits();
    int n;
    n = 0;
    while (owed > 0 && n < TMO) begin
      tick();
      n++;
    end
    if (owed > 0) note_timeout("credits were never all handed back");
  endtask

  task automatic run_step(step_t s);
    reg_data_t d;
    reg_data_t drop0;
    write_check(REG_FVAL_LOW, s.fval_low, s.fval_low, "fval_low");
    write_check(REG_LVAL_LOW, s.lval_low, s.lval_low, "lval_low");
    write_check(REG_N_COL, s.n_col, s.n_col, "n_col");
    write_check(REG_N_ROW, s.n_row, s.n_row, "n_row");
    exp_fval_low = s.fval_low;
    exp_lval_low = s.lval_low;
    exp_col = s.n_col;
    exp_row = s.n_row;
    mode = s.mode;
    chk_content = s.mode != M_HOLD;
    rx_cnt = 0;
    read_reg(REG_DROP_CNT, drop0);
    tb_en = 1'b1;
    write_check(REG_CTRL, 16'd1, 16'd1, "ctrl");
    for (int f = 0; f < s.frames; f++) begin
      wait_fval(1'b1);
      if (f == s.frames - 1) begin
        tb_en = 1'b0;  // the running frame still completes
        write_reg(REG_CTRL, 16'd0);
      end
      if (s.mid_col != 0) write_check(REG_N_COL, s.mid_col, s.mid_col, "n_col mid frame");
      wait_fval(1'b0);
    end
    if (s.mode == M_HOLD) begin
      repeat (BUF_DEPTH * 2) tick();
      check_count("words without credit", rx_cnt, CREDIT_MAX);
      mode = M_PROMPT;  // release the withheld credits
    end
    wait_words(s.frames * s.n_col * s.n_row, drop0);
    wait_credits();
    read_reg(REG_FRAME_CNT, d);
    check_reg("frame count", d, s.exp_frames);
  endtask

  initial begin
    reg_data_t d;
    void'($urandom(30));
    reset = 1'b0;
    cl_z_pclk = 1'b1;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    credit_ret = 1'b0;
    repeat (8) @(posedge reset);
    #2;
    cl_z_pclk = 1'b0;

    check_bit("fval", fval, 1'b0);
    check_bit("lval", lval, 1'b0);
    check_bit("out_valid", out_valid, 1'b0);
    for (int k = 0; k < N_TAPS; k++) begin
      check_tap($sformatf("tap %0d", k), tap_w[k], BASE_TAB[k]);
    end
    read_reg(REG_CTRL, d);
    check_reg("ctrl", d, 16'd0);
    read_reg(REG_FVAL_LOW, d);
    check_reg("fval_low", d, 16'd40);
    read_reg(REG_LVAL_LOW, d);
    check_reg("lval_low", d, 16'd7);
    read_reg(REG_N_COL, d);
    check_reg("n_col", d, 16'd6);
    read_reg(REG_N_ROW, d);
    check_reg("n_row", d, 16'd4);
    read_reg(REG_FRAME_CNT, d);
    check_reg("frame count", d, 16'd0);
    read_reg(REG_DROP_CNT, d);
    check_reg("drop count", d, 16'd0);

    write_check(REG_FVAL_LOW, 16'd12, 16'd12, "fval_low");
    write_check(REG_FRAME_CNT, 16'h55aa, 16'd0, "frame count write");
    write_check(REG_DROP_CNT, 16'h1234, 16'd0, "drop count write");

    // camera must stay idle while enable is clear
    repeat (200) begin
      tick();
      check_bit("fval disabled", fval, 1'b0);
      check_bit("lval disabled", lval, 1'b0);
    end

    for (int i = 0; i < N_STEPS; i++) begin
      run_step(steps[i]);
    end

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
